/* filelist.f */
verilog/axi_lite_pkg.sv
verilog/pwm_regs_pkg.sv
verilog/reg_access_decode.sv
verilog/pwm_reg_bank.sv
verilog/bus_response.sv
verilog/pwm_axi_regs.sv
sim/pwm_axi_regs_properties.sv
sim/tb_pwm_axi_regs.sv

/* Makefile */
TOP  = tb_pwm_axi_regs
SRCS = $(shell cat filelist.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir

/* sim/tb_pwm_axi_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_axi_regs;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES  = 5;
	// bound on bus transactions over all tests, each a few cycles
	localparam int MAX_XACTS    = 120;
	localparam int XACT_CYCLES  = 6;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_XACTS * XACT_CYCLES +
		4 * HOLD_CYCLES + 100;

	logic                     aclk;
	logic                     aresetn;
	axi_lite_pkg::addr_t      araddr;
	logic                     arvalid;
	logic                     arready;
	logic                     rready;
	logic                     rvalid;
	axi_lite_pkg::data_t      rdata;
	logic                     rresp;
	axi_lite_pkg::addr_t      awaddr;
	logic                     awvalid;
	logic                     awready;
	axi_lite_pkg::data_t      wdata;
	axi_lite_pkg::strb_t      wstrb;
	logic                     wvalid;
	logic                     wready;
	logic                     bready;
	logic                     bvalid;
	logic                     bresp;
	axi_lite_pkg::size_t      read_size;
	logic                     pwm1;
	logic                     pwm2;
	pwm_regs_pkg::pwm_mode_t  pwm1_mode;
	pwm_regs_pkg::pwm_count_t pwm1_period;
	pwm_regs_pkg::pwm_count_t pwm1_thr1;
	pwm_regs_pkg::pwm_count_t pwm1_thr2;
	pwm_regs_pkg::pwm_step_t  pwm1_step;
	pwm_regs_pkg::pwm_mode_t  pwm2_mode;
	pwm_regs_pkg::pwm_count_t pwm2_period;
	pwm_regs_pkg::pwm_count_t pwm2_thr1;
	pwm_regs_pkg::pwm_count_t pwm2_thr2;
	pwm_regs_pkg::pwm_step_t  pwm2_step;

	integer                   seed;
	// expected contents, indexed by word offset
	axi_lite_pkg::data_t      model_regs [0:11];

	pwm_axi_regs i_pwm_axi_regs (
		.s_axi_aclk_i      (aclk),
		.s_axi_aresetn_i   (aresetn),
		.s_axi_araddr_i    (araddr),
		.s_axi_arvalid_i   (arvalid),
		.s_axi_arready_o   (arready),
		.s_axi_rready_i    (rready),
		.s_axi_rvalid_o    (rvalid),
		.s_axi_rdata_o     (rdata),
		.s_axi_rresp_o     (rresp),
		.s_axi_awaddr_i    (awaddr),
		.s_axi_awvalid_i   (awvalid),
		.s_axi_awready_o   (awready),
		.s_axi_wdata_i     (wdata),
		.s_axi_wstrb_i     (wstrb),
		.s_axi_wvalid_i    (wvalid),
		.s_axi_wready_o    (wready),
		.s_axi_bready_i    (bready),
		.s_axi_bvalid_o    (bvalid),
		.s_axi_bresp_o     (bresp),
		.read_size_i       (read_size),
		.pwm1_i            (pwm1),
		.pwm2_i            (pwm2),
		.pwm1_mode_o       (pwm1_mode),
		.pwm1_period_o     (pwm1_period),
		.pwm1_threshold1_o (pwm1_thr1),
		.pwm1_threshold2_o (pwm1_thr2),
		.pwm1_step_o       (pwm1_step),
		.pwm2_mode_o       (pwm2_mode),
		.pwm2_period_o     (pwm2_period),
		.pwm2_threshold1_o (pwm2_thr1),
		.pwm2_threshold2_o (pwm2_thr2),
		.pwm2_step_o       (pwm2_step)
	);

	initial begin
		aclk = 1'b0;
		forever #(CLK_PERIOD / 2) aclk = ~aclk;
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	task automatic report_mismatch(input string what, input axi_lite_pkg::data_t got,
		input axi_lite_pkg::data_t exp);
		$display("Fail at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
		$display("=== FAIL ===");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_data(input string what, input axi_lite_pkg::data_t got,
		input axi_lite_pkg::data_t exp);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_resp(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(what, axi_lite_pkg::data_t'(got), axi_lite_pkg::data_t'(exp));
	endtask

	task automatic check_count(input string what, input pwm_regs_pkg::pwm_count_t got,
		input pwm_regs_pkg::pwm_count_t exp);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_step(input string what, input pwm_regs_pkg::pwm_step_t got,
		input pwm_regs_pkg::pwm_step_t exp);
		if (got !== exp)
			report_mismatch(what, axi_lite_pkg::data_t'(got), axi_lite_pkg::data_t'(exp));
	endtask

	task automatic check_mode(input string what, input pwm_regs_pkg::pwm_mode_t got,
		input pwm_regs_pkg::pwm_mode_t exp);
		if (got !== exp)
			report_mismatch(what, axi_lite_pkg::data_t'(got), axi_lite_pkg::data_t'(exp));
	endtask

	function automatic axi_lite_pkg::lane_mask_t lanes_for(input logic [3:0] code);
		if (code[3])
			return 32'hFFFF_FFFF;
		if (code[1])
			return 32'h0000_FFFF;
		return 32'h0000_00FF;
	endfunction

	// bits that a register really stores
	function automatic axi_lite_pkg::data_t field_bits(input int idx);
		case (idx)
			0, 1:    return 32'h0000_0003;
			8, 9:    return 32'h0000_0FFF;
			10, 11:  return 32'h0000_0001;
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	// -1 for anything that is not a mapped word
	function automatic int reg_index(input axi_lite_pkg::addr_t addr);
		if ((addr & ~pwm_regs_pkg::PWM_ADDR_MASK) != pwm_regs_pkg::PWM_BASE_ADDR)
			return -1;
		if (addr[1:0] != 2'b00 || addr[7:0] > 8'h2C)
			return -1;
		return int'(addr[7:2]);
	endfunction

	function automatic axi_lite_pkg::addr_t ofs_addr(input pwm_regs_pkg::reg_offset_t ofs);
		return pwm_regs_pkg::PWM_BASE_ADDR | axi_lite_pkg::addr_t'(ofs);
	endfunction

	task automatic axi_write(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
		input axi_lite_pkg::strb_t strb, input int hold, output logic resp);
		@(negedge aclk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!(awready && wready))
			@(negedge aclk);
		@(negedge aclk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge aclk);
		resp = bresp;
		// host stalls, response must stay put
		for (int i = 0; i < hold; i++) begin
			check_resp("bvalid under stall", bvalid, 1'b1);
			check_resp("bresp under stall", bresp, resp);
			check_resp("awready under stall", awready, 1'b0);
			check_resp("wready under stall", wready, 1'b0);
			@(negedge aclk);
		end
		bready = 1'b1;
		@(negedge aclk);
		bready = 1'b0;
		check_resp("bvalid after bready", bvalid, 1'b0);
	endtask

	task automatic axi_read(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::size_t size,
		input int hold, output axi_lite_pkg::data_t data, output logic resp);
		@(negedge aclk);
		araddr = addr;
		read_size = size;
		arvalid = 1'b1;
		while (!arready)
			@(negedge aclk);
		@(negedge aclk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge aclk);
		data = rdata;
		resp = rresp;
		for (int i = 0; i < hold; i++) begin
			check_resp("rvalid under stall", rvalid, 1'b1);
			check_resp("rresp under stall", rresp, resp);
			check_data("rdata under stall", rdata, data);
			check_resp("arready under stall", arready, 1'b0);
			@(negedge aclk);
		end
		rready = 1'b1;
		@(negedge aclk);
		rready = 1'b0;
		check_resp("rvalid after rready", rvalid, 1'b0);
	endtask

	task automatic write_reg(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
		input axi_lite_pkg::strb_t strb, input int hold);
		int idx;
		logic resp;
		axi_lite_pkg::lane_mask_t m;
		idx = reg_index(addr);
		m = lanes_for(strb);
		axi_write(addr, data, strb, hold, resp);
		if (idx >= 0 && idx < 10) begin
			check_resp($sformatf("write resp at 0x%08h", addr), resp, axi_lite_pkg::RESP_OKAY);
			model_regs[idx] = ((model_regs[idx] & ~m) | (data & m)) & field_bits(idx);
		end else begin
			check_resp($sformatf("write resp at 0x%08h", addr), resp, axi_lite_pkg::RESP_ERROR);
		end
	endtask

	task automatic read_reg(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::size_t size,
		input int hold);
		int idx;
		axi_lite_pkg::data_t data;
		logic resp;
		idx = reg_index(addr);
		axi_read(addr, size, hold, data, resp);
		if (idx >= 0) begin
			check_resp($sformatf("read resp at 0x%08h", addr), resp, axi_lite_pkg::RESP_OKAY);
			check_data($sformatf("read data at 0x%08h", addr), data,
				model_regs[idx] & lanes_for(size));
		end else begin
			check_resp($sformatf("read resp at 0x%08h", addr), resp, axi_lite_pkg::RESP_ERROR);
			check_data($sformatf("read data at 0x%08h", addr), data, '0);
		end
	endtask

	task automatic read_all();
		for (int i = 0; i < 12; i++)
			read_reg(ofs_addr(pwm_regs_pkg::reg_offset_t'(4 * i)), 4'hF, 0);
	endtask

	task automatic check_outputs();
		check_mode("pwm1_mode_o", pwm1_mode, pwm_regs_pkg::pwm_mode_t'(model_regs[0]));
		check_mode("pwm2_mode_o", pwm2_mode, pwm_regs_pkg::pwm_mode_t'(model_regs[1]));
		check_count("pwm1_period_o", pwm1_period, model_regs[2]);
		check_count("pwm2_period_o", pwm2_period, model_regs[3]);
		check_count("pwm1_threshold1_o", pwm1_thr1, model_regs[4]);
		check_count("pwm1_threshold2_o", pwm1_thr2, model_regs[5]);
		check_count("pwm2_threshold1_o", pwm2_thr1, model_regs[6]);
		check_count("pwm2_threshold2_o", pwm2_thr2, model_regs[7]);
		check_step("pwm1_step_o", pwm1_step, pwm_regs_pkg::pwm_step_t'(model_regs[8]));
		check_step("pwm2_step_o", pwm2_step, pwm_regs_pkg::pwm_step_t'(model_regs[9]));
	endtask

	task automatic test_reset_values();
		read_all();
		check_outputs();
	endtask

	task automatic test_word_writes();
		for (int i = 0; i < 10; i++)
			write_reg(ofs_addr(pwm_regs_pkg::reg_offset_t'(4 * i)), $random(seed), 4'hF, 0);
		check_outputs();
		read_all();
	endtask

	task automatic test_lane_access();
		int picks [4] = '{2, 6, 8, 1};
		axi_lite_pkg::addr_t addr;
		for (int k = 0; k < 4; k++) begin
			addr = ofs_addr(pwm_regs_pkg::reg_offset_t'(4 * picks[k]));
			write_reg(addr, $random(seed), 4'h3, 0);
			read_reg(addr, 4'h2, 0);
			write_reg(addr, $random(seed), 4'h4, 0);
			read_reg(addr, 4'h1, 0);
			read_reg(addr, 4'hF, 0);
		end
		check_outputs();
	endtask

	task automatic test_error_paths();
		write_reg(32'h2003_0004, $random(seed), 4'hF, 0);
		write_reg(ofs_addr(8'h30), $random(seed), 4'hF, 0);
		write_reg(ofs_addr(8'h06), $random(seed), 4'hF, 0);
		write_reg(ofs_addr(pwm_regs_pkg::OFS_OUT1), 32'hFFFF_FFFF, 4'hF, 0);
		write_reg(ofs_addr(pwm_regs_pkg::OFS_OUT2), 32'hFFFF_FFFF, 4'hF, 0);
		read_reg(32'h1002_0008, 4'hF, 0);
		read_reg(ofs_addr(8'h40), 4'hF, 0);
		read_reg(ofs_addr(8'h06), 4'hF, 0);
		check_outputs();
		read_all();
	endtask

	task automatic test_status_inputs();
		for (int n = 0; n < 2; n++) begin
			@(negedge aclk);
			pwm1 = (n == 0);
			pwm2 = (n != 0);
			repeat (2) @(negedge aclk);
			model_regs[10] = axi_lite_pkg::data_t'(pwm1);
			model_regs[11] = axi_lite_pkg::data_t'(pwm2);
			read_reg(ofs_addr(pwm_regs_pkg::OFS_OUT1), 4'h1, 0);
			read_reg(ofs_addr(pwm_regs_pkg::OFS_OUT2), 4'hF, 0);
		end
	endtask

	task automatic test_back_pressure();
		write_reg(ofs_addr(pwm_regs_pkg::OFS_THR1_2), $random(seed), 4'hF, HOLD_CYCLES);
		read_reg(ofs_addr(pwm_regs_pkg::OFS_THR1_2), 4'hF, HOLD_CYCLES);
		read_reg(ofs_addr(pwm_regs_pkg::OFS_STEP2), 4'h2, HOLD_CYCLES);
		check_outputs();
	endtask

	initial begin
		seed = 32'h9436_4337;
		aresetn = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		read_size = '0;
		pwm1 = 1'b0;
		pwm2 = 1'b0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(negedge aclk);
		aresetn = 1'b0;

		test_reset_values();
		test_word_writes();
		test_lane_access();
		test_error_paths();
		test_status_inputs();
		test_back_pressure();

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/pwm_axi_regs_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_axi_regs_properties (
	input wire logic                s_axi_aclk_i,
	input wire logic                s_axi_aresetn_i,
	input wire logic                awready_i,
	input wire logic                wready_i,
	input wire logic                bvalid_i,
	input wire logic                bready_i,
	input wire logic                arready_i,
	input wire logic                rvalid_i,
	input wire logic                rready_i,
	input wire axi_lite_pkg::data_t rdata_i
);

	// reset is active high on this block
	a_idle_after_reset: assert property (@(posedge s_axi_aclk_i)
		s_axi_aresetn_i |=> !bvalid_i && !rvalid_i)
		else $error("bvalid or rvalid set right after reset");

	a_bvalid_hold: assert property (@(posedge s_axi_aclk_i) disable iff (s_axi_aresetn_i)
		bvalid_i && !bready_i |=> bvalid_i)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge s_axi_aclk_i) disable iff (s_axi_aresetn_i)
		rvalid_i && !rready_i |=> rvalid_i)
		else $error("rvalid dropped before rready");

	a_rdata_stable: assert property (@(posedge s_axi_aclk_i) disable iff (s_axi_aresetn_i)
		rvalid_i && !rready_i |=> $stable(rdata_i))
		else $error("rdata changed while stalled");

	// one response outstanding per channel
	a_write_ready_low: assert property (@(posedge s_axi_aclk_i) disable iff (s_axi_aresetn_i)
		bvalid_i |-> !awready_i && !wready_i)
		else $error("write ready high with a pending response");

	a_read_ready_low: assert property (@(posedge s_axi_aclk_i) disable iff (s_axi_aresetn_i)
		rvalid_i |-> !arready_i)
		else $error("arready high with a pending response");

endmodule

bind pwm_axi_regs pwm_axi_regs_properties i_pwm_axi_regs_properties (
	.s_axi_aclk_i    (s_axi_aclk_i),
	.s_axi_aresetn_i (s_axi_aresetn_i),
	.awready_i       (s_axi_awready_o),
	.wready_i        (s_axi_wready_o),
	.bvalid_i        (s_axi_bvalid_o),
	.bready_i        (s_axi_bready_i),
	.arready_i       (s_axi_arready_o),
	.rvalid_i        (s_axi_rvalid_o),
	.rready_i        (s_axi_rready_i),
	.rdata_i         (s_axi_rdata_o)
);

`default_nettype wire

/* verilog/pwm_axi_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_axi_regs (
	input  wire logic                s_axi_aclk_i,
	input  wire logic                s_axi_aresetn_i,
	// read address and data
	input  wire axi_lite_pkg::addr_t s_axi_araddr_i,
	input  wire logic                s_axi_arvalid_i,
	output logic                     s_axi_arready_o,
	input  wire logic                s_axi_rready_i,
	output logic                     s_axi_rvalid_o,
	output axi_lite_pkg::data_t      s_axi_rdata_o,
	output logic                     s_axi_rresp_o,
	// write address, data and response
	input  wire axi_lite_pkg::addr_t s_axi_awaddr_i,
	input  wire logic                s_axi_awvalid_i,
	output logic                     s_axi_awready_o,
	input  wire axi_lite_pkg::data_t s_axi_wdata_i,
	input  wire axi_lite_pkg::strb_t s_axi_wstrb_i,
	input  wire logic                s_axi_wvalid_i,
	output logic                     s_axi_wready_o,
	input  wire logic                s_axi_bready_i,
	output logic                     s_axi_bvalid_o,
	output logic                     s_axi_bresp_o,
	input  wire axi_lite_pkg::size_t read_size_i,
	// channel configuration and status
	input  wire logic                pwm1_i,
	input  wire logic                pwm2_i,
	output pwm_regs_pkg::pwm_mode_t  pwm1_mode_o,
	output pwm_regs_pkg::pwm_count_t pwm1_period_o,
	output pwm_regs_pkg::pwm_count_t pwm1_threshold1_o,
	output pwm_regs_pkg::pwm_count_t pwm1_threshold2_o,
	output pwm_regs_pkg::pwm_step_t  pwm1_step_o,
	output pwm_regs_pkg::pwm_mode_t  pwm2_mode_o,
	output pwm_regs_pkg::pwm_count_t pwm2_period_o,
	output pwm_regs_pkg::pwm_count_t pwm2_threshold1_o,
	output pwm_regs_pkg::pwm_count_t pwm2_threshold2_o,
	output pwm_regs_pkg::pwm_step_t  pwm2_step_o
);

	pwm_regs_pkg::reg_sel_t   wr_sel;
	pwm_regs_pkg::reg_sel_t   rd_sel;
	axi_lite_pkg::lane_mask_t wr_mask;
	axi_lite_pkg::lane_mask_t rd_mask;
	axi_lite_pkg::data_t      rd_data;
	logic                     wr_en;
	logic                     wr_hit;
	logic                     rd_hit;
	logic                     wr_fire;

	reg_access_decode i_reg_access_decode (
		.awaddr_i    (s_axi_awaddr_i),
		.araddr_i    (s_axi_araddr_i),
		.wstrb_i     (s_axi_wstrb_i),
		.read_size_i (read_size_i),
		.wr_fire_i   (wr_fire),
		.wr_sel_o    (wr_sel),
		.wr_mask_o   (wr_mask),
		.wr_en_o     (wr_en),
		.wr_hit_o    (wr_hit),
		.rd_sel_o    (rd_sel),
		.rd_mask_o   (rd_mask),
		.rd_hit_o    (rd_hit)
	);

	pwm_reg_bank i_pwm_reg_bank (
		.s_axi_aclk_i      (s_axi_aclk_i),
		.s_axi_aresetn_i   (s_axi_aresetn_i),
		.wr_en_i           (wr_en),
		.wr_sel_i          (wr_sel),
		.wr_mask_i         (wr_mask),
		.wdata_i           (s_axi_wdata_i),
		.rd_sel_i          (rd_sel),
		.rd_mask_i         (rd_mask),
		.pwm1_i            (pwm1_i),
		.pwm2_i            (pwm2_i),
		.pwm1_mode_o       (pwm1_mode_o),
		.pwm1_period_o     (pwm1_period_o),
		.pwm1_threshold1_o (pwm1_threshold1_o),
		.pwm1_threshold2_o (pwm1_threshold2_o),
		.pwm1_step_o       (pwm1_step_o),
		.pwm2_mode_o       (pwm2_mode_o),
		.pwm2_period_o     (pwm2_period_o),
		.pwm2_threshold1_o (pwm2_threshold1_o),
		.pwm2_threshold2_o (pwm2_threshold2_o),
		.pwm2_step_o       (pwm2_step_o),
		.rd_data_o         (rd_data)
	);

	// the bank read lookup is combinational, so the read accept pulse stays inside
	bus_response i_bus_response (
		.s_axi_aclk_i    (s_axi_aclk_i),
		.s_axi_aresetn_i (s_axi_aresetn_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_rready_i  (s_axi_rready_i),
		.wr_hit_i        (wr_hit),
		.rd_hit_i        (rd_hit),
		.rd_data_i       (rd_data),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bresp_o   (s_axi_bresp_o),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_rresp_o   (s_axi_rresp_o),
		.wr_fire_o       (wr_fire),
		.rd_fire_o       ()
	);

endmodule

`default_nettype wire

/* verilog/bus_response.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_response (
	input  wire logic                s_axi_aclk_i,
	input  wire logic                s_axi_aresetn_i,
	input  wire logic                s_axi_awvalid_i,
	input  wire logic                s_axi_wvalid_i,
	input  wire logic                s_axi_bready_i,
	input  wire logic                s_axi_arvalid_i,
	input  wire logic                s_axi_rready_i,
	input  wire logic                wr_hit_i,
	input  wire logic                rd_hit_i,
	input  wire axi_lite_pkg::data_t rd_data_i,
	output logic                     s_axi_awready_o,
	output logic                     s_axi_wready_o,
	output logic                     s_axi_bvalid_o,
	output logic                     s_axi_bresp_o,
	output logic                     s_axi_arready_o,
	output logic                     s_axi_rvalid_o,
	output axi_lite_pkg::data_t      s_axi_rdata_o,
	output logic                     s_axi_rresp_o,
	output logic                     wr_fire_o,
	output logic                     rd_fire_o
);

	logic                bvalid_r;
	logic                bresp_r;
	logic                rvalid_r;
	logic                rresp_r;
	axi_lite_pkg::data_t rdata_r;

	// one response outstanding per channel
	assign s_axi_awready_o = ~bvalid_r;
	assign s_axi_wready_o  = ~bvalid_r;
	assign s_axi_arready_o = ~rvalid_r;

	assign wr_fire_o = s_axi_awvalid_i & s_axi_wvalid_i & s_axi_awready_o & s_axi_wready_o;
	assign rd_fire_o = s_axi_arvalid_i & s_axi_arready_o;

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			bvalid_r <= 1'b0;
			rvalid_r <= 1'b0;
		end else begin
			if (wr_fire_o)
				bvalid_r <= 1'b1;
			else if (s_axi_bready_i)
				bvalid_r <= 1'b0;

			if (rd_fire_o)
				rvalid_r <= 1'b1;
			else if (s_axi_rready_i)
				rvalid_r <= 1'b0;
		end
	end

	// response payload, held while valid is up
	always_ff @(posedge s_axi_aclk_i) begin
		if (wr_fire_o)
			bresp_r <= wr_hit_i ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_ERROR;
		if (rd_fire_o) begin
			rdata_r <= rd_data_i;
			rresp_r <= rd_hit_i ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_ERROR;
		end
	end

	assign s_axi_bvalid_o = bvalid_r;
	assign s_axi_bresp_o  = bresp_r;
	assign s_axi_rvalid_o = rvalid_r;
	assign s_axi_rdata_o  = rdata_r;
	assign s_axi_rresp_o  = rresp_r;

endmodule

`default_nettype wire

/* verilog/pwm_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_reg_bank (
	input  wire logic                     s_axi_aclk_i,
	input  wire logic                     s_axi_aresetn_i,
	input  wire logic                     wr_en_i,
	input  wire pwm_regs_pkg::reg_sel_t   wr_sel_i,
	input  wire axi_lite_pkg::lane_mask_t wr_mask_i,
	input  wire axi_lite_pkg::data_t      wdata_i,
	input  wire pwm_regs_pkg::reg_sel_t   rd_sel_i,
	input  wire axi_lite_pkg::lane_mask_t rd_mask_i,
	input  wire logic                     pwm1_i,
	input  wire logic                     pwm2_i,
	output pwm_regs_pkg::pwm_mode_t       pwm1_mode_o,
	output pwm_regs_pkg::pwm_count_t      pwm1_period_o,
	output pwm_regs_pkg::pwm_count_t      pwm1_threshold1_o,
	output pwm_regs_pkg::pwm_count_t      pwm1_threshold2_o,
	output pwm_regs_pkg::pwm_step_t       pwm1_step_o,
	output pwm_regs_pkg::pwm_mode_t       pwm2_mode_o,
	output pwm_regs_pkg::pwm_count_t      pwm2_period_o,
	output pwm_regs_pkg::pwm_count_t      pwm2_threshold1_o,
	output pwm_regs_pkg::pwm_count_t      pwm2_threshold2_o,
	output pwm_regs_pkg::pwm_step_t       pwm2_step_o,
	output axi_lite_pkg::data_t           rd_data_o
);

	// keep unselected lanes of the old value
	function automatic axi_lite_pkg::data_t merge(
		input axi_lite_pkg::data_t      old_val,
		input axi_lite_pkg::data_t      new_val,
		input axi_lite_pkg::lane_mask_t mask
	);
		merge = (old_val & ~mask) | (new_val & mask);
	endfunction

	pwm_regs_pkg::pwm_mode_t  mode1_r;
	pwm_regs_pkg::pwm_mode_t  mode2_r;
	pwm_regs_pkg::pwm_count_t period1_r;
	pwm_regs_pkg::pwm_count_t period2_r;
	pwm_regs_pkg::pwm_count_t thr1_1_r;
	pwm_regs_pkg::pwm_count_t thr1_2_r;
	pwm_regs_pkg::pwm_count_t thr2_1_r;
	pwm_regs_pkg::pwm_count_t thr2_2_r;
	pwm_regs_pkg::pwm_step_t  step1_r;
	pwm_regs_pkg::pwm_step_t  step2_r;
	logic                     out1_r;
	logic                     out2_r;
	axi_lite_pkg::data_t      rd_field;

	always_ff @(posedge s_axi_aclk_i) begin
		if (s_axi_aresetn_i) begin
			mode1_r   <= '0;
			mode2_r   <= '0;
			period1_r <= '0;
			period2_r <= '0;
			thr1_1_r  <= '0;
			thr1_2_r  <= '0;
			thr2_1_r  <= '0;
			thr2_2_r  <= '0;
			step1_r   <= '0;
			step2_r   <= '0;
			out1_r    <= 1'b0;
			out2_r    <= 1'b0;
		end else begin
			// pwm inputs sampled every cycle
			out1_r <= pwm1_i;
			out2_r <= pwm2_i;
			if (wr_en_i) begin
				case (wr_sel_i)
					pwm_regs_pkg::REG_MODE1: mode1_r <= pwm_regs_pkg::pwm_mode_t'(
						merge(axi_lite_pkg::data_t'(mode1_r), wdata_i, wr_mask_i));
					pwm_regs_pkg::REG_MODE2: mode2_r <= pwm_regs_pkg::pwm_mode_t'(
						merge(axi_lite_pkg::data_t'(mode2_r), wdata_i, wr_mask_i));
					pwm_regs_pkg::REG_PERIOD1: period1_r <= merge(period1_r, wdata_i, wr_mask_i);
					pwm_regs_pkg::REG_PERIOD2: period2_r <= merge(period2_r, wdata_i, wr_mask_i);
					pwm_regs_pkg::REG_THR1_1: thr1_1_r <= merge(thr1_1_r, wdata_i, wr_mask_i);
					pwm_regs_pkg::REG_THR1_2: thr1_2_r <= merge(thr1_2_r, wdata_i, wr_mask_i);
					pwm_regs_pkg::REG_THR2_1: thr2_1_r <= merge(thr2_1_r, wdata_i, wr_mask_i);
					pwm_regs_pkg::REG_THR2_2: thr2_2_r <= merge(thr2_2_r, wdata_i, wr_mask_i);
					pwm_regs_pkg::REG_STEP1: step1_r <= pwm_regs_pkg::pwm_step_t'(
						merge(axi_lite_pkg::data_t'(step1_r), wdata_i, wr_mask_i));
					pwm_regs_pkg::REG_STEP2: step2_r <= pwm_regs_pkg::pwm_step_t'(
						merge(axi_lite_pkg::data_t'(step2_r), wdata_i, wr_mask_i));
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		rd_field = '0;
		case (rd_sel_i)
			pwm_regs_pkg::REG_MODE1:   rd_field = axi_lite_pkg::data_t'(mode1_r);
			pwm_regs_pkg::REG_MODE2:   rd_field = axi_lite_pkg::data_t'(mode2_r);
			pwm_regs_pkg::REG_PERIOD1: rd_field = period1_r;
			pwm_regs_pkg::REG_PERIOD2: rd_field = period2_r;
			pwm_regs_pkg::REG_THR1_1:  rd_field = thr1_1_r;
			pwm_regs_pkg::REG_THR1_2:  rd_field = thr1_2_r;
			pwm_regs_pkg::REG_THR2_1:  rd_field = thr2_1_r;
			pwm_regs_pkg::REG_THR2_2:  rd_field = thr2_2_r;
			pwm_regs_pkg::REG_STEP1:   rd_field = axi_lite_pkg::data_t'(step1_r);
			pwm_regs_pkg::REG_STEP2:   rd_field = axi_lite_pkg::data_t'(step2_r);
			pwm_regs_pkg::REG_OUT1:    rd_field = axi_lite_pkg::data_t'(out1_r);
			pwm_regs_pkg::REG_OUT2:    rd_field = axi_lite_pkg::data_t'(out2_r);
			default:                   rd_field = '0;
		endcase
	end

	assign rd_data_o = rd_field & rd_mask_i;

	assign pwm1_mode_o       = mode1_r;
	assign pwm1_period_o     = period1_r;
	assign pwm1_threshold1_o = thr1_1_r;
	assign pwm1_threshold2_o = thr1_2_r;
	assign pwm1_step_o       = step1_r;
	assign pwm2_mode_o       = mode2_r;
	assign pwm2_period_o     = period2_r;
	assign pwm2_threshold1_o = thr2_1_r;
	assign pwm2_threshold2_o = thr2_2_r;
	assign pwm2_step_o       = step2_r;

endmodule

`default_nettype wire

/* verilog/reg_access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_access_decode (
	input  wire axi_lite_pkg::addr_t       awaddr_i,
	input  wire axi_lite_pkg::addr_t       araddr_i,
	input  wire axi_lite_pkg::strb_t       wstrb_i,
	input  wire axi_lite_pkg::size_t       read_size_i,
	input  wire logic                      wr_fire_i,
	output pwm_regs_pkg::reg_sel_t         wr_sel_o,
	output axi_lite_pkg::lane_mask_t       wr_mask_o,
	output logic                           wr_en_o,
	output logic                           wr_hit_o,
	output pwm_regs_pkg::reg_sel_t         rd_sel_o,
	output axi_lite_pkg::lane_mask_t       rd_mask_o,
	output logic                           rd_hit_o
);

	function automatic pwm_regs_pkg::reg_sel_t offset_to_sel(
		input pwm_regs_pkg::reg_offset_t ofs
	);
		case (ofs)
			pwm_regs_pkg::OFS_MODE1:   offset_to_sel = pwm_regs_pkg::REG_MODE1;
			pwm_regs_pkg::OFS_MODE2:   offset_to_sel = pwm_regs_pkg::REG_MODE2;
			pwm_regs_pkg::OFS_PERIOD1: offset_to_sel = pwm_regs_pkg::REG_PERIOD1;
			pwm_regs_pkg::OFS_PERIOD2: offset_to_sel = pwm_regs_pkg::REG_PERIOD2;
			pwm_regs_pkg::OFS_THR1_1:  offset_to_sel = pwm_regs_pkg::REG_THR1_1;
			pwm_regs_pkg::OFS_THR1_2:  offset_to_sel = pwm_regs_pkg::REG_THR1_2;
			pwm_regs_pkg::OFS_THR2_1:  offset_to_sel = pwm_regs_pkg::REG_THR2_1;
			pwm_regs_pkg::OFS_THR2_2:  offset_to_sel = pwm_regs_pkg::REG_THR2_2;
			pwm_regs_pkg::OFS_STEP1:   offset_to_sel = pwm_regs_pkg::REG_STEP1;
			pwm_regs_pkg::OFS_STEP2:   offset_to_sel = pwm_regs_pkg::REG_STEP2;
			pwm_regs_pkg::OFS_OUT1:    offset_to_sel = pwm_regs_pkg::REG_OUT1;
			pwm_regs_pkg::OFS_OUT2:    offset_to_sel = pwm_regs_pkg::REG_OUT2;
			default:                   offset_to_sel = pwm_regs_pkg::REG_NONE;
		endcase
	endfunction

	// word wins over half, anything else is a byte
	function automatic axi_lite_pkg::lane_mask_t code_to_mask(input axi_lite_pkg::strb_t code);
		if (code[axi_lite_pkg::SIZE_WORD_BIT])
			code_to_mask = axi_lite_pkg::MASK_WORD;
		else if (code[axi_lite_pkg::SIZE_HALF_BIT])
			code_to_mask = axi_lite_pkg::MASK_HALF;
		else
			code_to_mask = axi_lite_pkg::MASK_BYTE;
	endfunction

	logic                      aw_in_range;
	logic                      ar_in_range;
	pwm_regs_pkg::reg_offset_t aw_offset;
	pwm_regs_pkg::reg_offset_t ar_offset;
	pwm_regs_pkg::reg_sel_t    aw_sel;
	pwm_regs_pkg::reg_sel_t    ar_sel;
	logic                      aw_writable;

	assign aw_in_range = (awaddr_i & ~pwm_regs_pkg::PWM_ADDR_MASK) == pwm_regs_pkg::PWM_BASE_ADDR;
	assign ar_in_range = (araddr_i & ~pwm_regs_pkg::PWM_ADDR_MASK) == pwm_regs_pkg::PWM_BASE_ADDR;

	assign aw_offset = pwm_regs_pkg::reg_offset_t'(awaddr_i & pwm_regs_pkg::PWM_ADDR_MASK);
	assign ar_offset = pwm_regs_pkg::reg_offset_t'(araddr_i & pwm_regs_pkg::PWM_ADDR_MASK);

	assign aw_sel = aw_in_range ? offset_to_sel(aw_offset) : pwm_regs_pkg::REG_NONE;
	assign ar_sel = ar_in_range ? offset_to_sel(ar_offset) : pwm_regs_pkg::REG_NONE;

	// status registers are a miss for writes
	assign aw_writable = (aw_sel != pwm_regs_pkg::REG_NONE) &&
		(aw_sel != pwm_regs_pkg::REG_OUT1) &&
		(aw_sel != pwm_regs_pkg::REG_OUT2);

	assign wr_sel_o  = aw_writable ? aw_sel : pwm_regs_pkg::REG_NONE;
	assign wr_hit_o  = aw_writable;
	assign wr_en_o   = wr_fire_i & aw_writable;
	assign wr_mask_o = code_to_mask(wstrb_i);

	assign rd_sel_o  = ar_sel;
	assign rd_hit_o  = ar_sel != pwm_regs_pkg::REG_NONE;
	assign rd_mask_o = code_to_mask(read_size_i);

endmodule

`default_nettype wire

/* verilog/pwm_regs_pkg.sv */
`default_nettype none

package pwm_regs_pkg;

	localparam logic [31:0] PWM_BASE_ADDR = 32'h2002_0000;
	localparam logic [31:0] PWM_ADDR_MASK = 32'h0000_00FF;

	localparam int MODE_W  = 2;
	localparam int COUNT_W = 32;
	localparam int STEP_W  = 12;
	localparam int OFS_W   = 8;

	typedef logic [MODE_W-1:0]  pwm_mode_t;
	typedef logic [COUNT_W-1:0] pwm_count_t;
	typedef logic [STEP_W-1:0]  pwm_step_t;
	typedef logic [OFS_W-1:0]   reg_offset_t;

	// word offsets inside the block
	localparam reg_offset_t OFS_MODE1   = 8'h00;
	localparam reg_offset_t OFS_MODE2   = 8'h04;
	localparam reg_offset_t OFS_PERIOD1 = 8'h08;
	localparam reg_offset_t OFS_PERIOD2 = 8'h0C;
	localparam reg_offset_t OFS_THR1_1  = 8'h10;
	localparam reg_offset_t OFS_THR1_2  = 8'h14;
	localparam reg_offset_t OFS_THR2_1  = 8'h18;
	localparam reg_offset_t OFS_THR2_2  = 8'h1C;
	localparam reg_offset_t OFS_STEP1   = 8'h20;
	localparam reg_offset_t OFS_STEP2   = 8'h24;
	// status, read only
	localparam reg_offset_t OFS_OUT1    = 8'h28;
	localparam reg_offset_t OFS_OUT2    = 8'h2C;

	typedef enum logic [3:0] {
		REG_NONE,
		REG_MODE1,
		REG_MODE2,
		REG_PERIOD1,
		REG_PERIOD2,
		REG_THR1_1,
		REG_THR1_2,
		REG_THR2_1,
		REG_THR2_2,
		REG_STEP1,
		REG_STEP2,
		REG_OUT1,
		REG_OUT2
	} reg_sel_t;

endpackage

`default_nettype wire

/* verilog/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	// read size code, same bit meaning as the strobe
	typedef logic [STRB_W-1:0] size_t;
	typedef logic [DATA_W-1:0] lane_mask_t;

	// size code bits, checked word first then half
	localparam int SIZE_WORD_BIT = 3;
	localparam int SIZE_HALF_BIT = 1;

	localparam lane_mask_t MASK_WORD = 32'hFFFF_FFFF;
	localparam lane_mask_t MASK_HALF = 32'h0000_FFFF;
	localparam lane_mask_t MASK_BYTE = 32'h0000_00FF;

	// 1 is okay here, not the usual encoding
	localparam logic RESP_OKAY  = 1'b1;
	localparam logic RESP_ERROR = 1'b0;

endpackage

`default_nettype wire
